// File: source/frame_reader_pkg.sv
//**********************************************************
// frame reader shared definitions
// bus widths, DDR frame layout and common types used by the
// scheduler, address generator and beat router
//**********************************************************
`default_nettype none

package frame_reader_pkg;

    localparam int addr_w = 28;                 // DDR word address
    localparam int data_w = 256;                // one read beat
    localparam int num_ch = 4;                  // display channels
    localparam int ch_w = $clog2(num_ch);
    localparam int beat_w = 8;

    // each channel owns two banks, channels packed back to back
    localparam int frame_offset = 40960;        // bank 1 above bank 0
    localparam int ch_stride = 2 * frame_offset;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [ch_w-1:0]   ch_t;
    typedef logic [beat_w-1:0] beat_t;

    // request a burst, then drain its beats
    typedef enum logic {
        sched_req,
        sched_data
    } sched_state_t;

endpackage

`default_nettype wire

// File: source/rd_channel_sched.sv
//**********************************************************
// read channel scheduler
// round-robin FSM over the display channels, one AXI read
// burst per channel per turn
//**********************************************************
`default_nettype none

module rd_channel_sched (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    arready,
    input  wire                    burst_done,
    output logic                   arvalid,
    output logic                   rready,
    output frame_reader_pkg::ch_t  cur_ch,
    output logic                   ar_fire
);
    import frame_reader_pkg::*;

    sched_state_t state;
    sched_state_t state_nxt;
    ch_t          ch_nxt;

    // handshake signals come straight from the state, no request in reset
    assign arvalid = rst && (state == sched_req);
    assign rready = (state == sched_data);
    assign ar_fire = arvalid && arready;   // address accepted this cycle

    always_comb begin
        state_nxt = state;
        ch_nxt = cur_ch;
        case (state)
            sched_req: begin
                if (ar_fire) begin
                    state_nxt = sched_data;
                end
            end
            sched_data: begin
                // hand over to the next channel once rlast is taken
                if (burst_done) begin
                    state_nxt = sched_req;
                    if (cur_ch == ch_t'(num_ch - 1)) begin
                        ch_nxt = '0;
                    end else begin
                        ch_nxt = ch_t'(cur_ch + 1'b1);
                    end
                end
            end
            default: begin
                state_nxt = sched_req;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= sched_req;
            cur_ch <= '0;    // channel 0 goes first
        end else begin
            state <= state_nxt;
            cur_ch <= ch_nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/rd_addr_gen.sv
//**********************************************************
// read address generator
// per-channel frame offset and ping-pong bank, forms the
// DDR word address for the current channel's burst
//**********************************************************
`default_nettype none

module rd_addr_gen #(
    parameter int burst_len   = 20,
    parameter int frame_words = 240
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire frame_reader_pkg::ch_t   cur_ch,
    input  wire                          ar_fire,
    output frame_reader_pkg::addr_t      araddr
);
    import frame_reader_pkg::*;

    addr_t offset_q [num_ch];   // word offset inside current frame
    logic  bank_q [num_ch];     // which of the two frame buffers
    addr_t offset_step;
    logic  frame_end;
    addr_t ch_base;
    addr_t bank_base;

    // offset after this burst, and whether the frame is used up
    assign offset_step = offset_q[cur_ch] + addr_t'(burst_len);
    assign frame_end = (offset_step >= addr_t'(frame_words));

    // channel base, bank base and offset for the selected channel
    always_comb begin
        ch_base = addr_t'(cur_ch) * addr_t'(ch_stride);
        if (bank_q[cur_ch]) begin
            bank_base = addr_t'(frame_offset);
        end else begin
            bank_base = '0;
        end
        araddr = ch_base + bank_base + offset_q[cur_ch];
    end

    // only the channel being served moves, and only on the AR handshake
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_ch; i++) begin
                offset_q[i] <= '0;
                bank_q[i] <= 1'b0;
            end
        end else if (ar_fire) begin
            if (frame_end) begin
                offset_q[cur_ch] <= '0;             // back to frame start
                bank_q[cur_ch] <= ~bank_q[cur_ch];  // swap buffer
            end else begin
                offset_q[cur_ch] <= offset_step;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rd_beat_router.sv
//**********************************************************
// read beat router
// takes R channel beats, counts them within the burst and
// registers them out tagged with channel and beat index
//**********************************************************
`default_nettype none

module rd_beat_router #(
    parameter int burst_len = 20
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rvalid,
    input  wire                          rlast,
    input  wire frame_reader_pkg::data_t rdata,
    input  wire                          rready,
    input  wire frame_reader_pkg::ch_t   cur_ch,
    output logic                         burst_done,
    output logic                         pix_valid,
    output frame_reader_pkg::data_t      pix_data,
    output frame_reader_pkg::ch_t        pix_ch,
    output frame_reader_pkg::beat_t      pix_beat,
    output logic                         pix_last
);
    import frame_reader_pkg::*;

    logic  beat_take;
    beat_t beat_cnt;   // index of the next beat in this burst

    assign beat_take = rvalid && rready;
    assign burst_done = beat_take && rlast;

    // cleared by rlast, also held inside one burst length
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat_cnt <= '0;
        end else if (beat_take) begin
            if (rlast || (beat_cnt == beat_t'(burst_len - 1))) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= beat_take;   // one pulse per accepted beat
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take) begin
            pix_data <= rdata;
            pix_ch <= cur_ch;
            pix_beat <= beat_cnt;
            pix_last <= rlast;
        end
    end

endmodule

`default_nettype wire

// File: source/frame_reader_top.sv
//**********************************************************
// four-channel frame reader
// reads display frames out of DDR over the AXI read path
// and hands out channel-tagged pixel words
//**********************************************************
`default_nettype none

module frame_reader_top #(
    parameter int burst_len   = 20,
    parameter int frame_words = 240
) (
    input  wire                          clk,
    input  wire                          rst,
    // AR channel
    output logic                         arvalid,
    output frame_reader_pkg::addr_t      araddr,
    input  wire                          arready,
    // R channel
    input  wire                          rvalid,
    input  wire frame_reader_pkg::data_t rdata,
    input  wire                          rlast,
    output logic                         rready,
    // pixel words to the line buffers, no back-pressure
    output logic                         pix_valid,
    output frame_reader_pkg::data_t      pix_data,
    output frame_reader_pkg::ch_t        pix_ch,
    output frame_reader_pkg::beat_t      pix_beat,
    output logic                         pix_last
);
    import frame_reader_pkg::*;

    ch_t  cur_ch;       // channel being served
    logic ar_fire;
    logic burst_done;   // rlast beat taken

    rd_channel_sched u_sched (
        .clk        (clk),
        .rst        (rst),
        .arready    (arready),
        .burst_done (burst_done),
        .arvalid    (arvalid),
        .rready     (rready),
        .cur_ch     (cur_ch),
        .ar_fire    (ar_fire)
    );

    rd_addr_gen #(
        .burst_len   (burst_len),
        .frame_words (frame_words)
    ) u_addr (
        .clk     (clk),
        .rst     (rst),
        .cur_ch  (cur_ch),
        .ar_fire (ar_fire),
        .araddr  (araddr)
    );

    rd_beat_router #(
        .burst_len (burst_len)
    ) u_beat (
        .clk        (clk),
        .rst        (rst),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rdata      (rdata),
        .rready     (rready),
        .cur_ch     (cur_ch),
        .burst_done (burst_done),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_ch     (pix_ch),
        .pix_beat   (pix_beat),
        .pix_last   (pix_last)
    );

endmodule

`default_nettype wire

// File: tests/tb_axi_mem_model.sv
//**********************************************************
// AXI read memory model
// answers each read address with one burst of data taken
// from the address, with optional random arready/rvalid gaps
//**********************************************************
`default_nettype none

module tb_axi_mem_model #(
    parameter int burst_len = 20
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          stall_en,
    input  wire                          arvalid,
    input  wire frame_reader_pkg::addr_t araddr,
    output logic                         arready,
    output logic                         rvalid,
    output frame_reader_pkg::data_t      rdata,
    output logic                         rlast,
    input  wire                          rready
);
    timeunit 1ns;
    timeprecision 100ps;
    import frame_reader_pkg::*;

    integer seed;
    logic   busy;       // a burst is being returned
    addr_t  base;
    int     beat_idx;
    logic   ar_take;
    logic   r_take;
    addr_t  ar_addr;

    initial begin
        seed = 32'h13fb_8eb8;
        busy = 1'b0;
        base = '0;
        beat_idx = 0;
        ar_take = 1'b0;
        r_take = 1'b0;
        ar_addr = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rlast = 1'b0;
    end

    // handshakes seen here complete on the next rising edge
    always @(negedge clk) begin
        ar_take = arvalid && arready;
        r_take = rvalid && rready;
        ar_addr = araddr;
    end

    always @(posedge clk) begin
        #2;
        if (!rst) begin
            busy = 1'b0;
            beat_idx = 0;
        end else if (!busy && ar_take) begin
            busy = 1'b1;
            base = ar_addr;
            beat_idx = 0;
        end else if (busy && r_take) begin
            if (beat_idx == burst_len - 1) begin
                busy = 1'b0;
            end else begin
                beat_idx++;
            end
        end
        if (!rst || busy) begin
            arready = 1'b0;
        end else begin
            arready = !(stall_en && (($random(seed) % 3) == 0));
        end
        if (!busy) begin
            rvalid = 1'b0;
        end else if (!(rvalid && !r_take)) begin   // offered beat stays until taken
            rvalid = !(stall_en && (($random(seed) % 3) == 0));
        end
        rdata = data_t'(base + addr_t'(beat_idx));
        rlast = busy && (beat_idx == burst_len - 1);
    end

endmodule

`default_nettype wire

// File: tests/tb_frame_reader.sv
//**********************************************************
// frame reader testbench
// directed tests of round-robin issue, address stepping,
// frame wrap, beat tagging and AXI stalls
//**********************************************************
`default_nettype none

module tb_frame_reader;
    timeunit 1ns;
    timeprecision 100ps;
    import frame_reader_pkg::*;

    localparam int burst_len = 4;
    localparam int frame_words = 16;
    localparam int clk_period = 100;
    localparam int reset_cycles = 16;
    localparam int total_bursts = 56;   // sum over all tests

    logic  clk;
    logic  rst;
    logic  stall_en;
    logic  arvalid;
    addr_t araddr;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    logic  rlast;
    logic  rready;
    logic  pix_valid;
    data_t pix_data;
    ch_t   pix_ch;
    beat_t pix_beat;
    logic  pix_last;

    addr_t ar_addr_q [$];
    data_t pix_data_q [$];
    ch_t   pix_ch_q [$];
    beat_t pix_beat_q [$];
    logic  pix_last_q [$];
    int    exp_offset [num_ch];   // reference offset and bank per channel
    logic  exp_bank [num_ch];
    addr_t last_addr [num_ch];
    int    burst_count;
    int    stall_cycles;
    logic  ar_waiting;
    addr_t held_addr;
    sched_state_t state_now;

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    frame_reader_top #(
        .burst_len   (burst_len),
        .frame_words (frame_words)
    ) u_frame_reader_top (
        .clk (clk), .rst (rst),
        .arvalid (arvalid), .araddr (araddr), .arready (arready),
        .rvalid (rvalid), .rdata (rdata), .rlast (rlast), .rready (rready),
        .pix_valid (pix_valid), .pix_data (pix_data), .pix_ch (pix_ch),
        .pix_beat (pix_beat), .pix_last (pix_last)
    );

    tb_axi_mem_model #(
        .burst_len (burst_len)
    ) u_mem (
        .clk (clk), .rst (rst), .stall_en (stall_en),
        .arvalid (arvalid), .araddr (araddr), .arready (arready),
        .rvalid (rvalid), .rdata (rdata), .rlast (rlast), .rready (rready)
    );

    task automatic compare(input data_t actual, input data_t expected, input string what);
        if (actual !== expected) begin
            $display("Error at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // log AR and pixel handshakes mid-cycle, where everything is settled
    always @(negedge clk) begin
        if (rst) begin
            if (ar_waiting) begin
                compare(data_t'(arvalid), data_t'(1), "arvalid dropped before arready");
                compare(data_t'(araddr), data_t'(held_addr), "araddr moved while waiting");
            end
            if (arvalid && arready) ar_addr_q.push_back(araddr);
            if ((arvalid && !arready) || (rready && !rvalid)) stall_cycles++;
            ar_waiting = arvalid && !arready;
            held_addr = araddr;
        end else begin
            ar_waiting = 1'b0;
        end
        if (pix_valid) begin
            pix_data_q.push_back(pix_data);
            pix_ch_q.push_back(pix_ch);
            pix_beat_q.push_back(pix_beat);
            pix_last_q.push_back(pix_last);
        end
    end

    function automatic addr_t expected_addr(input int c);
        int bank_words;
        bank_words = exp_bank[c] ? frame_offset : 0;
        return addr_t'(c * ch_stride + bank_words + exp_offset[c]);
    endfunction

    // one request and its burst_len pixel words for channel c
    task automatic check_burst(input int c);
        addr_t exp_addr;
        data_t word;
        ch_t   ch_now;
        beat_t beat_now;
        logic  last_now;
        exp_addr = expected_addr(c);
        while (ar_addr_q.size() == 0) @(posedge clk);
        last_addr[c] = ar_addr_q.pop_front();
        compare(data_t'(last_addr[c]), data_t'(exp_addr), $sformatf("address of ch %0d", c));
        exp_offset[c] += burst_len;
        if (exp_offset[c] >= frame_words) begin
            exp_offset[c] = 0;
            exp_bank[c] = ~exp_bank[c];
        end
        for (int k = 0; k < burst_len; k++) begin
            while (pix_data_q.size() == 0) @(posedge clk);
            word = pix_data_q.pop_front();
            ch_now = pix_ch_q.pop_front();
            beat_now = pix_beat_q.pop_front();
            last_now = pix_last_q.pop_front();
            compare(word, data_t'(last_addr[c] + addr_t'(k)), "pixel data");
            compare(data_t'(ch_now), data_t'(c), "pixel channel");
            compare(data_t'(beat_now), data_t'(k), "beat index");
            compare(data_t'(last_now), data_t'(k == burst_len - 1), "last flag");
        end
        burst_count++;
    endtask

    task automatic reset_test();
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            compare(data_t'(arvalid), data_t'(0), "arvalid during reset");
            compare(data_t'(pix_valid), data_t'(0), "pix_valid during reset");
            compare(data_t'(rready), data_t'(0), "rready during reset");
        end
        @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);
        compare(data_t'(pix_valid), data_t'(0), "pix_valid after release");
        check_burst(0);
        compare(data_t'(last_addr[0]), data_t'(0), "first request address");
    endtask

    task automatic round_robin_test();
        int c;
        for (int i = 1; i < 2 * num_ch; i++) begin
            c = burst_count % num_ch;
            check_burst(c);
            if (i < num_ch) compare(data_t'(last_addr[c]), data_t'(c * ch_stride), "channel base");
        end
    endtask

    task automatic address_step_test();
        int    c;
        addr_t prev;
        logic  in_frame;
        repeat (2 * num_ch) begin
            c = burst_count % num_ch;
            prev = last_addr[c];
            in_frame = (exp_offset[c] != 0);
            check_burst(c);
            if (in_frame) compare(data_t'(last_addr[c] - prev), data_t'(burst_len), "step");
        end
    endtask

    task automatic frame_wrap_test();
        int c;
        repeat (num_ch) begin
            c = burst_count % num_ch;
            check_burst(c);
            compare(data_t'(last_addr[c]), data_t'(c * ch_stride + frame_offset), "bank 1 start");
        end
        repeat ((frame_words / burst_len - 1) * num_ch) check_burst(burst_count % num_ch);
        repeat (num_ch) begin
            c = burst_count % num_ch;
            check_burst(c);
            compare(data_t'(last_addr[c]), data_t'(c * ch_stride), "bank 0 start again");
        end
    endtask

    // the cycle after pix_last carries no word, the next burst needs a new request first
    task automatic beat_tagging_test();
        repeat (num_ch) begin
            check_burst(burst_count % num_ch);
            @(negedge clk);
            compare(data_t'(pix_valid), data_t'(0), "extra word after pix_last");
        end
    endtask

    task automatic stall_test();
        @(posedge clk);
        #1 stall_en = 1'b1;
        stall_cycles = 0;
        repeat (4 * num_ch) check_burst(burst_count % num_ch);
        compare(data_t'(stall_cycles != 0), data_t'(1), "no stall cycles seen");
        @(posedge clk);
        #1 stall_en = 1'b0;
    endtask

    // limit of about 50 cycles per burst
    initial begin
        #((reset_cycles + total_bursts * 50 + 200) * clk_period);
        state_now = u_frame_reader_top.u_sched.state;
        $display("Timeout: run stuck after %0d bursts, scheduler in %s",
                 burst_count, state_now.name());
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst = 1'b0;
        stall_en = 1'b0;
        burst_count = 0;
        stall_cycles = 0;
        ar_waiting = 1'b0;
        held_addr = '0;
        for (int i = 0; i < num_ch; i++) begin
            exp_offset[i] = 0;
            exp_bank[i] = 1'b0;
            last_addr[i] = '0;
        end
        reset_test();
        round_robin_test();
        address_step_test();
        frame_wrap_test();
        beat_tagging_test();
        stall_test();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/frame_reader_pkg.sv
source/rd_channel_sched.sv
source/rd_addr_gen.sv
source/rd_beat_router.sv
source/frame_reader_top.sv
tests/tb_axi_mem_model.sv
tests/tb_frame_reader.sv

// File: run.sh
#!/bin/sh
# build and run the frame reader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_frame_reader \
    -Mdir obj_dir -f sim.f

# the testbench stops with a non-zero status on failure, the log decides
./obj_dir/Vtb_frame_reader > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "run.sh: simulation reported a failure"
    exit 1
fi
echo "run.sh: simulation finished cleanly"
exit 0
